//--- common/l2_pkg.sv
// Widths and line types shared by the L2 slice
// Operation codes, cache geometry and credit sizes
`default_nettype none

package l2_pkg;
	// One cache line and its byte enables
	typedef logic [511:0] line_t;
	typedef logic [63:0] mask_t;

	// Line address; the set index is its low four bits
	typedef logic [25:0] line_addr_t;
	typedef logic [3:0] set_t;
	typedef logic [1:0] way_t;

	// Data array index, way above set
	typedef logic [5:0] cache_index_t;

	typedef logic [1:0] strand_t;
	typedef logic [2:0] l2_op_t;

	// Request operations
	localparam l2_op_t L2REQ_LOAD = 3'b000;
	localparam l2_op_t L2REQ_STORE = 3'b001;
	localparam l2_op_t L2REQ_LOAD_SYNC = 3'b100;
	localparam l2_op_t L2REQ_STORE_SYNC = 3'b101;

	// Cache geometry
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;
	localparam int NUM_STRANDS = 4;

	// Flow control
	localparam int REQ_QUEUE_DEPTH = 4;
	localparam int RESP_CREDITS = 4;
endpackage

`default_nettype wire

//--- logic/l2_request_queue.sv
// Request FIFO in front of the tag stage
// Returns one request credit per popped entry
`timescale 1ns/1ps
`default_nettype none

module l2_request_queue(
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire l2_pkg::line_addr_t req_address,
	input wire l2_pkg::strand_t req_strand,
	input wire l2_pkg::l2_op_t req_op,
	input wire l2_pkg::line_t req_data,
	input wire l2_pkg::mask_t req_mask,
	input wire q_pop,
	output logic q_valid,
	output l2_pkg::line_addr_t q_address,
	output l2_pkg::strand_t q_strand,
	output l2_pkg::l2_op_t q_op,
	output l2_pkg::line_t q_data,
	output l2_pkg::mask_t q_mask,
	output logic req_credit);

	import l2_pkg::*;

	logic [$clog2(REQ_QUEUE_DEPTH) - 1:0] write_ptr;
	logic [$clog2(REQ_QUEUE_DEPTH) - 1:0] read_ptr;
	logic [$clog2(REQ_QUEUE_DEPTH + 1) - 1:0] count;
	line_addr_t address_fifo[REQ_QUEUE_DEPTH];
	strand_t strand_fifo[REQ_QUEUE_DEPTH];
	l2_op_t op_fifo[REQ_QUEUE_DEPTH];
	line_t data_fifo[REQ_QUEUE_DEPTH];
	mask_t mask_fifo[REQ_QUEUE_DEPTH];

	// Head of queue
	assign q_valid = count != '0;
	assign q_address = address_fifo[read_ptr];
	assign q_strand = strand_fifo[read_ptr];
	assign q_op = op_fifo[read_ptr];
	assign q_data = data_fifo[read_ptr];
	assign q_mask = mask_fifo[read_ptr];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
			req_credit <= 1'b0;
		end
		else
		begin
			// Credit goes back the cycle after the entry leaves
			req_credit <= q_pop;
			if (req_valid)
				write_ptr <= write_ptr + 1'b1;

			if (q_pop)
				read_ptr <= read_ptr + 1'b1;

			if (req_valid && !q_pop)
				count <= count + 1'b1;
			else if (q_pop && !req_valid)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			address_fifo[write_ptr] <= req_address;
			strand_fifo[write_ptr] <= req_strand;
			op_fifo[write_ptr] <= req_op;
			data_fifo[write_ptr] <= req_data;
			mask_fifo[write_ptr] <= req_mask;
		end
	end
endmodule

`default_nettype wire

//--- l2_pipeline/l2_tag_lookup.sv
// Tag lookup stage with per-set round-robin victims
// Keeps the synchronized-load links and issues system memory reads
`timescale 1ns/1ps
`default_nettype none

module l2_tag_lookup(
	input wire clk,
	input wire reset,
	input wire stall_pipeline,
	input wire q_valid,
	input wire l2_pkg::line_addr_t q_address,
	input wire l2_pkg::strand_t q_strand,
	input wire l2_pkg::l2_op_t q_op,
	input wire l2_pkg::line_t q_data,
	input wire l2_pkg::mask_t q_mask,
	output logic q_pop,
	output logic tl_valid,
	output l2_pkg::line_addr_t tl_address,
	output l2_pkg::strand_t tl_strand,
	output l2_pkg::l2_op_t tl_op,
	output l2_pkg::line_t tl_data,
	output l2_pkg::mask_t tl_mask,
	output logic tl_cache_hit,
	output l2_pkg::way_t tl_hit_way,
	output l2_pkg::way_t tl_fill_way,
	output logic tl_store_sync_success,
	output logic sm_read_valid,
	output l2_pkg::line_addr_t sm_read_address);

	import l2_pkg::*;

	typedef logic [$bits(line_addr_t) - $bits(set_t) - 1:0] tag_t;

	tag_t tag_array[NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS - 1:0] line_valid[NUM_SETS];
	way_t victim_way[NUM_SETS];
	logic [NUM_STRANDS - 1:0] link_valid;
	line_addr_t link_address[NUM_STRANDS];
	set_t head_set;
	tag_t head_tag;
	logic head_hit;
	way_t head_hit_way;
	logic sync_success;
	logic clears_link;

	assign head_set = q_address[$bits(set_t) - 1:0];
	assign head_tag = q_address[$bits(line_addr_t) - 1:$bits(set_t)];
	assign q_pop = q_valid && !stall_pipeline;

	always_comb
	begin
		head_hit = 1'b0;
		head_hit_way = '0;
		for (int way = 0; way < NUM_WAYS; way++)
		begin
			if (line_valid[head_set][way] && tag_array[head_set][way] == head_tag)
			begin
				head_hit = 1'b1;
				head_hit_way = way_t'(way);
			end
		end
	end

	// Link must still be held by this strand for the same line
	assign sync_success = q_op == L2REQ_STORE_SYNC && link_valid[q_strand]
		&& link_address[q_strand] == q_address;
	assign clears_link = q_op == L2REQ_STORE || sync_success;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			line_valid <= '{default: '0};
			victim_way <= '{default: '0};
			link_valid <= '0;
			tl_valid <= 1'b0;
			sm_read_valid <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			tl_valid <= q_pop;
			sm_read_valid <= q_pop && !head_hit;
			if (q_pop)
			begin
				if (!head_hit)
				begin
					line_valid[head_set][victim_way[head_set]] <= 1'b1;
					victim_way[head_set] <= victim_way[head_set] + 1'b1;
				end

				for (int strand = 0; strand < NUM_STRANDS; strand++)
				begin
					if (clears_link && link_address[strand] == q_address)
						link_valid[strand] <= 1'b0;
				end

				if (q_op == L2REQ_LOAD_SYNC)
					link_valid[q_strand] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			if (q_pop && !head_hit)
				tag_array[head_set][victim_way[head_set]] <= head_tag;

			if (q_pop && q_op == L2REQ_LOAD_SYNC)
				link_address[q_strand] <= q_address;

			tl_address <= q_address;
			tl_strand <= q_strand;
			tl_op <= q_op;
			tl_data <= q_data;
			tl_mask <= q_mask;
			tl_cache_hit <= head_hit;
			tl_hit_way <= head_hit_way;
			tl_fill_way <= victim_way[head_set];
			tl_store_sync_success <= sync_success;
			sm_read_address <= q_address;
		end
	end
endmodule

`default_nettype wire

//--- l2_pipeline/l2_data_read.sv
// Data read stage holding the line array
// Bypasses the pending write stage update and captures the memory line
`timescale 1ns/1ps
`default_nettype none

module l2_data_read(
	input wire clk,
	input wire reset,
	input wire stall_pipeline,
	input wire tl_valid,
	input wire l2_pkg::line_addr_t tl_address,
	input wire l2_pkg::strand_t tl_strand,
	input wire l2_pkg::l2_op_t tl_op,
	input wire l2_pkg::line_t tl_data,
	input wire l2_pkg::mask_t tl_mask,
	input wire tl_cache_hit,
	input wire l2_pkg::way_t tl_hit_way,
	input wire l2_pkg::way_t tl_fill_way,
	input wire tl_store_sync_success,
	input wire l2_pkg::line_t sm_read_data,
	input wire wr_update_enable,
	input wire l2_pkg::cache_index_t wr_cache_write_index,
	input wire l2_pkg::line_t wr_update_data,
	output logic rd_l2req_valid,
	output l2_pkg::line_addr_t rd_l2req_address,
	output l2_pkg::strand_t rd_l2req_strand,
	output l2_pkg::l2_op_t rd_l2req_op,
	output l2_pkg::line_t rd_l2req_data,
	output l2_pkg::mask_t rd_l2req_mask,
	output logic rd_cache_hit,
	output l2_pkg::way_t rd_hit_l2_way,
	output l2_pkg::way_t rd_sm_fill_l2_way,
	output logic rd_store_sync_success,
	output l2_pkg::line_t rd_cache_mem_result,
	output logic rd_has_sm_data,
	output l2_pkg::line_t rd_sm_data);

	import l2_pkg::*;

	line_t cache_array[NUM_SETS * NUM_WAYS];
	cache_index_t read_index;
	line_t array_data;

	assign read_index = {tl_hit_way, tl_address[$bits(set_t) - 1:0]};

	// Update landing this edge must be seen by the following request
	always_comb
	begin
		if (wr_update_enable && wr_cache_write_index == read_index)
			array_data = wr_update_data;
		else
			array_data = cache_array[read_index];
	end

	always_ff @(posedge clk)
	begin
		if (wr_update_enable)
			cache_array[wr_cache_write_index] <= wr_update_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_l2req_valid <= 1'b0;
			rd_has_sm_data <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			rd_l2req_valid <= tl_valid;
			rd_has_sm_data <= tl_valid && !tl_cache_hit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			rd_l2req_address <= tl_address;
			rd_l2req_strand <= tl_strand;
			rd_l2req_op <= tl_op;
			rd_l2req_data <= tl_data;
			rd_l2req_mask <= tl_mask;
			rd_cache_hit <= tl_cache_hit;
			rd_hit_l2_way <= tl_hit_way;
			rd_sm_fill_l2_way <= tl_fill_way;
			rd_store_sync_success <= tl_store_sync_success;
			rd_cache_mem_result <= array_data;
			rd_sm_data <= sm_read_data;
		end
	end
endmodule

`default_nettype wire

//--- l2_pipeline/l2_cache_write.sv
// Write stage merging store data into the old line
// Drives the data array update and the registered stage outputs
`timescale 1ns/1ps
`default_nettype none

module l2_cache_write(
	input wire clk,
	input wire reset,
	input wire stall_pipeline,
	input wire rd_l2req_valid,
	input wire l2_pkg::line_addr_t rd_l2req_address,
	input wire l2_pkg::strand_t rd_l2req_strand,
	input wire l2_pkg::l2_op_t rd_l2req_op,
	input wire l2_pkg::line_t rd_l2req_data,
	input wire l2_pkg::mask_t rd_l2req_mask,
	input wire rd_cache_hit,
	input wire l2_pkg::way_t rd_hit_l2_way,
	input wire l2_pkg::way_t rd_sm_fill_l2_way,
	input wire rd_store_sync_success,
	input wire l2_pkg::line_t rd_cache_mem_result,
	input wire rd_has_sm_data,
	input wire l2_pkg::line_t rd_sm_data,
	output logic wr_l2req_valid,
	output l2_pkg::line_addr_t wr_l2req_address,
	output l2_pkg::strand_t wr_l2req_strand,
	output l2_pkg::l2_op_t wr_l2req_op,
	output logic wr_cache_hit,
	output logic wr_store_sync_success,
	output l2_pkg::line_t wr_data,
	output logic wr_update_enable,
	output l2_pkg::cache_index_t wr_cache_write_index,
	output l2_pkg::line_t wr_update_data);

	import l2_pkg::*;

	line_t old_line;
	line_t merged_line;
	set_t request_set;
	logic writes_line;
	logic is_store_op;

	// Memory line wins on a miss
	assign old_line = rd_has_sm_data ? rd_sm_data : rd_cache_mem_result;
	assign request_set = rd_l2req_address[$bits(set_t) - 1:0];

	always_comb
	begin
		for (int i = 0; i < $bits(mask_t); i++)
		begin
			if (rd_l2req_mask[i])
				merged_line[i * 8 +: 8] = rd_l2req_data[i * 8 +: 8];
			else
				merged_line[i * 8 +: 8] = old_line[i * 8 +: 8];
		end
	end

	assign is_store_op = rd_l2req_op == L2REQ_STORE || rd_l2req_op == L2REQ_STORE_SYNC;

	// Failed synchronized stores leave the line alone
	assign writes_line = rd_l2req_op == L2REQ_STORE
		|| (rd_l2req_op == L2REQ_STORE_SYNC && rd_store_sync_success);

	assign wr_cache_write_index = rd_cache_hit
		? {rd_hit_l2_way, request_set}
		: {rd_sm_fill_l2_way, request_set};

	// A miss always installs, merged if the request also writes
	assign wr_update_enable = rd_l2req_valid && (writes_line || !rd_cache_hit);
	assign wr_update_data = writes_line ? merged_line : old_line;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wr_l2req_valid <= 1'b0;
		else if (!stall_pipeline)
			wr_l2req_valid <= rd_l2req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			wr_l2req_address <= rd_l2req_address;
			wr_l2req_strand <= rd_l2req_strand;
			wr_l2req_op <= rd_l2req_op;
			wr_cache_hit <= rd_cache_hit;
			wr_store_sync_success <= rd_store_sync_success;
			if (is_store_op)
				wr_data <= merged_line;
			else
				wr_data <= old_line;
		end
	end
endmodule

`default_nettype wire

//--- logic/l2_response_unit.sv
// Response registers and response credit counter
// Derives the pipeline stall and writes stores through to memory
`timescale 1ns/1ps
`default_nettype none

module l2_response_unit(
	input wire clk,
	input wire reset,
	input wire wr_l2req_valid,
	input wire l2_pkg::line_addr_t wr_l2req_address,
	input wire l2_pkg::strand_t wr_l2req_strand,
	input wire l2_pkg::l2_op_t wr_l2req_op,
	input wire wr_cache_hit,
	input wire wr_store_sync_success,
	input wire l2_pkg::line_t wr_data,
	input wire resp_credit,
	output logic stall_pipeline,
	output logic resp_valid,
	output l2_pkg::line_addr_t resp_address,
	output l2_pkg::strand_t resp_strand,
	output l2_pkg::l2_op_t resp_op,
	output logic resp_hit,
	output logic resp_sync_success,
	output l2_pkg::line_t resp_data,
	output logic sm_write_valid,
	output l2_pkg::line_addr_t sm_write_address,
	output l2_pkg::line_t sm_write_data);

	import l2_pkg::*;

	typedef logic [$clog2(RESP_CREDITS + 1) - 1:0] credit_count_t;

	credit_count_t credit_count;
	logic departing;
	logic write_through;

	// Hold everything while a finished request has nowhere to go
	assign stall_pipeline = wr_l2req_valid && credit_count == '0;
	assign departing = wr_l2req_valid && !stall_pipeline;
	assign write_through = wr_l2req_op == L2REQ_STORE
		|| (wr_l2req_op == L2REQ_STORE_SYNC && wr_store_sync_success);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			credit_count <= credit_count_t'(RESP_CREDITS);
			resp_valid <= 1'b0;
			sm_write_valid <= 1'b0;
		end
		else
		begin
			resp_valid <= departing;
			sm_write_valid <= departing && write_through;
			if (departing && !resp_credit)
				credit_count <= credit_count - 1'b1;
			else if (resp_credit && !departing)
				credit_count <= credit_count + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (departing)
		begin
			resp_address <= wr_l2req_address;
			resp_strand <= wr_l2req_strand;
			resp_op <= wr_l2req_op;
			resp_hit <= wr_cache_hit;
			resp_sync_success <= wr_store_sync_success;
			resp_data <= wr_data;
			sm_write_address <= wr_l2req_address;
			sm_write_data <= wr_data;
		end
	end
endmodule

`default_nettype wire

//--- logic/l2_slice.sv
// L2 cache slice top level
// Request queue, tag, data read and write stages, response unit
`timescale 1ns/1ps
`default_nettype none

module l2_slice(
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire l2_pkg::line_addr_t req_address,
	input wire l2_pkg::strand_t req_strand,
	input wire l2_pkg::l2_op_t req_op,
	input wire l2_pkg::line_t req_data,
	input wire l2_pkg::mask_t req_mask,
	output logic req_credit,
	output logic resp_valid,
	output l2_pkg::line_addr_t resp_address,
	output l2_pkg::strand_t resp_strand,
	output l2_pkg::l2_op_t resp_op,
	output logic resp_hit,
	output logic resp_sync_success,
	output l2_pkg::line_t resp_data,
	input wire resp_credit,
	output logic sm_read_valid,
	output l2_pkg::line_addr_t sm_read_address,
	input wire l2_pkg::line_t sm_read_data,
	output logic sm_write_valid,
	output l2_pkg::line_addr_t sm_write_address,
	output l2_pkg::line_t sm_write_data);

	import l2_pkg::*;

	logic stall_pipeline;

	// Queue head
	logic q_valid;
	logic q_pop;
	line_addr_t q_address;
	strand_t q_strand;
	l2_op_t q_op;
	line_t q_data;
	mask_t q_mask;

	// Tag stage
	logic tl_valid;
	line_addr_t tl_address;
	strand_t tl_strand;
	l2_op_t tl_op;
	line_t tl_data;
	mask_t tl_mask;
	logic tl_cache_hit;
	way_t tl_hit_way;
	way_t tl_fill_way;
	logic tl_store_sync_success;

	// Data read stage
	logic rd_l2req_valid;
	line_addr_t rd_l2req_address;
	strand_t rd_l2req_strand;
	l2_op_t rd_l2req_op;
	line_t rd_l2req_data;
	mask_t rd_l2req_mask;
	logic rd_cache_hit;
	way_t rd_hit_l2_way;
	way_t rd_sm_fill_l2_way;
	logic rd_store_sync_success;
	line_t rd_cache_mem_result;
	logic rd_has_sm_data;
	line_t rd_sm_data;

	// Write stage
	logic wr_l2req_valid;
	line_addr_t wr_l2req_address;
	strand_t wr_l2req_strand;
	l2_op_t wr_l2req_op;
	logic wr_cache_hit;
	logic wr_store_sync_success;
	line_t wr_data;
	logic wr_update_enable;
	cache_index_t wr_cache_write_index;
	line_t wr_update_data;

	l2_request_queue request_queue_i(.*);

	l2_tag_lookup tag_lookup_i(.*);

	l2_data_read data_read_i(.*);

	l2_cache_write cache_write_i(.*);

	l2_response_unit response_unit_i(.*);
endmodule

`default_nettype wire

//--- testbench/l2_slice_sva.sv
// Credit and occupancy assertions
// Bound into the response unit and the request queue
`timescale 1ns/1ps
`default_nettype none

module l2_slice_sva(
	input wire clk,
	input wire reset,
	input wire take,
	input wire give,
	input wire [7:0] level,
	input wire [7:0] capacity);

	int assertion_failures = 0;
	int in_use;

	// Units taken and not yet given back, seen from outside the block
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			in_use <= 0;
		else
			in_use <= in_use + int'(take) - int'(give);
	end

	// Nothing is taken unless a slot or credit is free
	take_needs_room: assert property (@(posedge clk) disable iff (reset)
		take |-> in_use < int'(capacity))
		else
		begin
			$error("credit or queue slot taken with none free");
			assertion_failures++;
		end

	level_within_capacity: assert property (@(posedge clk) disable iff (reset)
		level <= capacity)
		else
		begin
			$error("count above its capacity");
			assertion_failures++;
		end
endmodule

bind l2_response_unit l2_slice_sva credit_sva_i(
	.clk(clk),
	.reset(reset),
	.take(resp_valid),
	.give(resp_credit),
	.level(8'(credit_count)),
	.capacity(8'(l2_pkg::RESP_CREDITS)));

bind l2_request_queue l2_slice_sva queue_sva_i(
	.clk(clk),
	.reset(reset),
	.take(req_valid),
	.give(q_pop),
	.level(8'(count)),
	.capacity(8'(l2_pkg::REQ_QUEUE_DEPTH)));

`default_nettype wire

//--- testbench/l2_slice_tb.sv
// Testbench for the L2 cache slice
// Random requests from a fixed seed, checked against a cache and memory model
`timescale 1ns/1ps
`default_nettype none

module l2_slice_tb;
	import l2_pkg::*;

	localparam int NUM_REQUESTS = 400;
	localparam int NUM_LINES = 48;
	localparam int EVICTION_REQUESTS = 60;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 12 + 200;

	logic clk;
	logic reset;
	logic req_valid;
	line_addr_t req_address;
	strand_t req_strand;
	l2_op_t req_op;
	line_t req_data;
	mask_t req_mask;
	logic req_credit;
	logic resp_valid;
	line_addr_t resp_address;
	strand_t resp_strand;
	l2_op_t resp_op;
	logic resp_hit;
	logic resp_sync_success;
	line_t resp_data;
	logic resp_credit;
	logic sm_read_valid;
	line_addr_t sm_read_address;
	line_t sm_read_data;
	logic sm_write_valid;
	line_addr_t sm_write_address;
	line_t sm_write_data;

	// Memory as the DUT sees it, and the same memory in request order
	line_t system_memory[line_addr_t];
	line_t model_memory[line_addr_t];

	// Cache model
	line_addr_t model_tag[NUM_SETS][NUM_WAYS];
	logic model_valid[NUM_SETS][NUM_WAYS];
	way_t model_victim[NUM_SETS];
	logic link_valid[NUM_STRANDS];
	line_addr_t link_address[NUM_STRANDS];
	line_addr_t last_sync_address[NUM_STRANDS];

	// Expected responses and write-through traffic, oldest first
	line_addr_t expect_address[$];
	strand_t expect_strand[$];
	l2_op_t expect_op[$];
	logic expect_hit[$];
	logic expect_sync[$];
	line_t expect_data[$];
	line_addr_t expect_sm_address[$];
	line_t expect_sm_data[$];

	int cycles;
	int issued;
	int responses;
	int req_credits;
	int resp_credits;
	int credits_owed;
	logic withholding;

	l2_slice dut_i(.*);

	always #50 clk = ~clk;

	// Every word of an unwritten line carries the full line address
	function automatic line_t fill_line(input line_addr_t address);
		line_t line;
		for (int w = 0; w < $bits(line_t) / 32; w++)
			line[w * 32 +: 32] = {6'(w), address} ^ 32'hc3a5_1e0f;
		return line;
	endfunction

	function automatic line_t system_line(input line_addr_t address);
		if (system_memory.exists(address))
			return system_memory[address];
		else
			return fill_line(address);
	endfunction

	function automatic line_t model_line(input line_addr_t address);
		if (model_memory.exists(address))
			return model_memory[address];
		else
			return fill_line(address);
	endfunction

	function automatic line_t merge_line(input line_t old_line, input line_t data,
		input mask_t mask);
		line_t merged;
		merged = old_line;
		for (int b = 0; b < $bits(mask_t); b++)
		begin
			if (mask[b])
				merged[b * 8 +: 8] = data[b * 8 +: 8];
		end
		return merged;
	endfunction

	// Eight sets in use with six lines each
	function automatic line_addr_t line_address(input int index);
		return {22'(index / 8 * 'h1d3 + 'h2a), 4'(index % 8)};
	endfunction

	// Failures counted by the bound assertion checkers
	function automatic int bound_failures();
		return dut_i.response_unit_i.credit_sva_i.assertion_failures
			+ dut_i.request_queue_i.queue_sva_i.assertion_failures;
	endfunction

	task automatic report_failure(input string message);
		$display("%s", message);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input logic [511:0] actual, input logic [511:0] expected,
		input string what);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	task automatic predict_request(input line_addr_t address, input strand_t strand,
		input l2_op_t op, input line_t data, input mask_t mask);
		set_t set_index;
		logic hit;
		logic sync_ok;
		logic is_store;
		line_t old_line;
		line_t result;
		set_index = address[$bits(set_t) - 1:0];
		hit = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (model_valid[set_index][w] && model_tag[set_index][w] == address)
				hit = 1'b1;
		end
		if (!hit)
		begin
			model_tag[set_index][model_victim[set_index]] = address;
			model_valid[set_index][model_victim[set_index]] = 1'b1;
			model_victim[set_index] = model_victim[set_index] + 1'b1;
		end
		sync_ok = op == L2REQ_STORE_SYNC && link_valid[strand] && link_address[strand] == address;
		is_store = op == L2REQ_STORE || op == L2REQ_STORE_SYNC;
		old_line = model_line(address);
		result = is_store ? merge_line(old_line, data, mask) : old_line;
		if (op == L2REQ_STORE || sync_ok)
		begin
			model_memory[address] = result;
			expect_sm_address.push_back(address);
			expect_sm_data.push_back(result);
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (link_address[s] == address)
					link_valid[s] = 1'b0;
			end
		end
		if (op == L2REQ_LOAD_SYNC)
		begin
			link_valid[strand] = 1'b1;
			link_address[strand] = address;
		end
		expect_address.push_back(address);
		expect_strand.push_back(strand);
		expect_op.push_back(op);
		expect_hit.push_back(hit);
		expect_sync.push_back(sync_ok);
		expect_data.push_back(result);
	endtask

	task automatic drive_request();
		int pick;
		if (issued < EVICTION_REQUESTS)
			req_address = line_address(($urandom % 5) * 8 + 3);
		else
			req_address = line_address($urandom % NUM_LINES);
		req_strand = strand_t'($urandom % NUM_STRANDS);
		pick = $urandom % 20;
		if (pick < 8)
			req_op = L2REQ_LOAD;
		else if (pick < 14)
			req_op = L2REQ_STORE;
		else if (pick < 17)
			req_op = L2REQ_LOAD_SYNC;
		else
			req_op = L2REQ_STORE_SYNC;
		// Half the synchronized stores go back to the strand's linked line
		if (req_op == L2REQ_STORE_SYNC && $urandom % 2 == 0)
			req_address = last_sync_address[req_strand];
		if (req_op == L2REQ_LOAD_SYNC)
			last_sync_address[req_strand] = req_address;
		for (int w = 0; w < $bits(line_t) / 32; w++)
			req_data[w * 32 +: 32] = $urandom;
		req_mask = {$urandom, $urandom};
		predict_request(req_address, req_strand, req_op, req_data, req_mask);
		req_valid = 1'b1;
		req_credits--;
		issued++;
	endtask

	task automatic serve_memory();
		if (sm_write_valid)
		begin
			if (expect_sm_address.size() == 0)
				report_failure("system memory was written with no store outstanding");
			else
			begin
				check_value(sm_write_address, expect_sm_address.pop_front(), "write address");
				check_value(sm_write_data, expect_sm_data.pop_front(), "write data");
				system_memory[sm_write_address] = sm_write_data;
			end
		end
		// A write presented this cycle is already visible here
		if (sm_read_valid)
			sm_read_data = system_line(sm_read_address);
	endtask

	task automatic collect_response();
		if (resp_valid)
		begin
			if (resp_credits == 0)
				report_failure("a response was sent with no response credit left");
			else if (expect_address.size() == 0)
				report_failure("a response arrived with no request outstanding");
			else
			begin
				check_value(resp_address, expect_address.pop_front(), "response address");
				check_value(resp_strand, expect_strand.pop_front(), "response strand");
				check_value(resp_op, expect_op.pop_front(), "response op");
				check_value(resp_hit, expect_hit.pop_front(), "response hit");
				check_value(resp_sync_success, expect_sync.pop_front(), "sync success");
				check_value(resp_data, expect_data.pop_front(), "response data");
				resp_credits--;
				credits_owed++;
				responses++;
			end
		end
		// Credit driven last cycle was taken at the edge just passed
		if (resp_credit)
			resp_credits++;
	endtask

	task automatic return_credit();
		if (withholding && $urandom % 24 == 0)
			withholding = 1'b0;
		else if (!withholding && $urandom % 64 == 0)
			withholding = 1'b1;
		if (credits_owed > 0 && (!withholding || issued == NUM_REQUESTS) && $urandom % 2 == 0)
		begin
			resp_credit = 1'b1;
			credits_owed--;
		end
		else
			resp_credit = 1'b0;
	endtask

	task automatic finish_run();
		check_value(req_credits, REQ_QUEUE_DEPTH, "request credits after drain");
		check_value(expect_sm_address.size(), 0, "write-throughs still expected");
		$display("*** PASSED ***");
		$finish;
	endtask

	initial
	begin
		void'($urandom(21));
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_address = '0;
		req_strand = '0;
		req_op = L2REQ_LOAD;
		req_data = '0;
		req_mask = '0;
		resp_credit = 1'b0;
		sm_read_data = '0;
		cycles = 0;
		issued = 0;
		responses = 0;
		req_credits = REQ_QUEUE_DEPTH;
		resp_credits = RESP_CREDITS;
		credits_owed = 0;
		withholding = 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
		begin
			model_victim[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				model_valid[s][w] = 1'b0;
		end
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			link_valid[s] = 1'b0;
			link_address[s] = '0;
			last_sync_address[s] = line_address(0);
		end
	end

	always @(negedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		else if (bound_failures() != 0)
			report_failure("a credit or queue assertion failed during the run");
		else if (reset)
		begin
			if (cycles == RESET_CYCLES)
				reset = 1'b0;
		end
		else
		begin
			serve_memory();
			collect_response();
			return_credit();
			if (req_credit)
				req_credits++;
			if (issued < NUM_REQUESTS && req_credits > 0 && $urandom % 4 != 0)
				drive_request();
			else
				req_valid = 1'b0;
			if (issued == NUM_REQUESTS && responses == NUM_REQUESTS)
				finish_run();
		end
	end
endmodule

`default_nettype wire

//--- tb.f
common/l2_pkg.sv
logic/l2_request_queue.sv
l2_pipeline/l2_tag_lookup.sv
l2_pipeline/l2_data_read.sv
l2_pipeline/l2_cache_write.sv
logic/l2_response_unit.sv
logic/l2_slice.sv
testbench/l2_slice_sva.sv
testbench/l2_slice_tb.sv

//--- Bender.yml
package:
  name: l2_slice

sources:
  - common/l2_pkg.sv
  - logic/l2_request_queue.sv
  - l2_pipeline/l2_tag_lookup.sv
  - l2_pipeline/l2_data_read.sv
  - l2_pipeline/l2_cache_write.sv
  - logic/l2_response_unit.sv
  - logic/l2_slice.sv
  - target: test
    files:
      - testbench/l2_slice_sva.sv
      - testbench/l2_slice_tb.sv
